// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv -f verilog.f --top-module issue_core_tb -Mdir obj_dir
	obj_dir/Vissue_core_tb | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/issue_core_assert.sv
`timescale 1ns/1ns

module issue_core_assert (
  input logic clk,
  input logic rst,
  input logic take0,
  input logic take1,
  input logic wb_load_en,
  input logic wb_alu_en
);

  import issue_pkg::*;

  // slot1 is younger, it only ever goes together with slot0
  take1_with_take0: assert property (@(posedge clk) disable iff (rst) take1 |-> take0)
    else $error("take1 pulsed without take0");

  take_writes_back: assert property (@(posedge clk) disable iff (rst)
    $past(take0, EXEC_DEPTH) |-> (wb_load_en || wb_alu_en))
    else $error("no writeback EXEC_DEPTH cycles after take0");

  dual_writes_both: assert property (@(posedge clk) disable iff (rst)
    $past(take0 && take1, EXEC_DEPTH) |-> (wb_load_en && wb_alu_en))
    else $error("dual issue did not write back on both ports");

  quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_load_en && !wb_alu_en)
    else $error("writeback enabled right after reset");

endmodule

bind issue_core issue_core_assert u_assert (
  .clk(clk),
  .rst(rst),
  .take0(take0),
  .take1(take1),
  .wb_load_en(wb_load_en),
  .wb_alu_en(wb_alu_en)
);

// File: sim/issue_core_tb.sv
`timescale 1ns/1ns

module issue_core_tb;

  import issue_pkg::*;

  typedef struct packed {
    int  at;  // cycle in which the writeback must show
    wb_t wb;
  } exp_wb_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic pair_valid = 1'b0;
  instr_t slot0_instr = '0;
  instr_t slot1_instr = '0;
  logic take0;
  logic take1;
  logic wb_load_en;
  logic wb_alu_en;
  reg_addr_t wb_load_addr;
  reg_addr_t wb_alu_addr;
  word_t wb_load_data;
  word_t wb_alu_data;

  logic [31:0] lfsr = 32'hffdad4e9;
  int cyc = 0;
  int value_errs = 0;
  int other_errs = 0;
  word_t ref_regs [32];
  int last_take [32];  // cycle of the latest take writing each register
  instr_t prog_q [$];
  exp_wb_t load_q [$];
  exp_wb_t alu_q [$];

  issue_core dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h80200003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic reg_addr_t pick_dest(input logic [2:0] hi);
    return {hi, 2'(lfsr_bits(2))};
  endfunction

  function automatic reg_addr_t pick_src();
    return {1'b0, 4'(lfsr_bits(4))};  // r0..r15, never a test destination range
  endfunction

  function automatic alu_op_e pick_op();
    return alu_op_e'(3'(lfsr_bits(32) % 5));
  endfunction

  function automatic instr_t mk_load(input reg_addr_t rt, input word_t imm);
    instr_t ins;
    ins = '0;
    ins.cls = CLS_LOAD;
    ins.rt = rt;
    ins.imm = imm;
    return ins;
  endfunction

  function automatic instr_t mk_alu(input alu_op_e op, input reg_addr_t ra, input reg_addr_t rb,
                                    input reg_addr_t rt);
    instr_t ins;
    ins = '0;
    ins.cls = CLS_ALU;
    ins.op = op;
    ins.ra = ra;
    ins.rb = rb;
    ins.rt = rt;
    return ins;
  endfunction

  function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  // in flight from the cycle after the take through the writeback cycle
  function automatic logic in_flight(input reg_addr_t r);
    return (cyc - last_take[r] >= 1) && (cyc - last_take[r] <= EXEC_DEPTH);
  endfunction

  function automatic logic src_conflict(input instr_t ins);
    return (ins.cls == CLS_ALU) && (in_flight(ins.ra) || in_flight(ins.rb));
  endfunction

  function automatic logic pair_ok(input instr_t s0, input instr_t s1);
    logic dep;
    dep = (s1.rt == s0.rt) || (s1.cls == CLS_ALU && (s1.ra == s0.rt || s1.rb == s0.rt));
    return (s0.cls != s1.cls) && !dep && !src_conflict(s1);
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      value_errs++;
      $display("** Error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
    if (got !== want) begin
      value_errs++;
      $display("** Error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_take(input string name, input logic [1:0] got, input logic [1:0] want);
    if (got !== want) begin
      value_errs++;
      $display("** Error: %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic finish_run();
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic compare_wb(input string port, input logic en, input reg_addr_t addr,
                            input word_t data, input wb_t want);
    if (!en) begin
      other_errs++;
      $display("%s missing its writeback in cycle %0d", port, cyc);
    end else begin
      check_addr({port, "_addr"}, addr, want.addr);
      check_word({port, "_data"}, data, want.data);
    end
  endtask

  // sequential reference, slot0 applied before slot1
  task automatic record_issue(input instr_t ins);
    exp_wb_t e;
    e.at = cyc + EXEC_DEPTH;
    e.wb.valid = 1'b1;
    e.wb.addr = ins.rt;
    if (ins.cls == CLS_LOAD) begin
      e.wb.data = ins.imm;
      load_q.push_back(e);
    end else begin
      e.wb.data = ref_alu(ins.op, ref_regs[ins.ra], ref_regs[ins.rb]);
      alu_q.push_back(e);
    end
    ref_regs[ins.rt] = e.wb.data;
    last_take[ins.rt] = cyc;
  endtask

  // program order; after a single take, slot1 moves up to slot0
  task automatic run_prog();
    instr_t s0;
    instr_t s1;
    logic t0;
    logic t1;
    logic want1;
    int n;
    while (prog_q.size() > 0) begin
      s0 = prog_q[0];
      s1 = (prog_q.size() > 1) ? prog_q[1] : prog_q[0];  // a copy never pairs
      @(negedge clk);
      pair_valid = 1'b1;
      slot0_instr = s0;
      slot1_instr = s1;
      t0 = 1'b0;
      t1 = 1'b0;
      n = 0;
      while (!t0) begin
        #1;
        t0 = take0;
        t1 = take1;
        if (!t0) begin
          n++;
          if (n > 10 * EXEC_DEPTH) begin
            other_errs++;
            $display("timeout, the pair was never taken");
            finish_run();
          end
          @(negedge clk);
        end
      end
      want1 = (prog_q.size() > 1) && pair_ok(s0, s1);
      if (src_conflict(s0)) begin
        other_errs++;
        $display("slot0 taken while one of its sources was still in flight");
      end
      check_take("take0_take1", {t0, t1}, {1'b1, want1});
      record_issue(s0);
      void'(prog_q.pop_front());
      if (t1 && prog_q.size() > 0) begin
        record_issue(s1);
        void'(prog_q.pop_front());
      end
    end
    @(negedge clk);
    pair_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (load_q.size() > 0 || alu_q.size() > 0) begin
      @(negedge clk);
      #1;
      n++;
      if (n > 10 * EXEC_DEPTH) begin
        other_errs++;
        $display("timeout, writebacks still outstanding");
        finish_run();
      end
    end
    @(negedge clk);
  endtask

  task automatic test_reset_idle();
    repeat (8) begin
      @(negedge clk);
      #1;
      check_take("take0_take1", {take0, take1}, 2'b00);
    end
  endtask

  task automatic test_single_loads();
    repeat (4) begin
      prog_q.push_back(mk_load(reg_addr_t'(lfsr_bits(5)), lfsr_bits(32)));
      run_prog();
    end
    drain();
  endtask

  task automatic test_dependent_alu();
    reg_addr_t a;
    reg_addr_t b;
    repeat (3) begin
      a = reg_addr_t'(lfsr_bits(5));
      b = reg_addr_t'(lfsr_bits(5));
      prog_q.push_back(mk_load(a, lfsr_bits(32)));
      prog_q.push_back(mk_load(b, lfsr_bits(32)));
      prog_q.push_back(mk_alu(pick_op(), a, b, reg_addr_t'(lfsr_bits(5))));
      run_prog();
      drain();
    end
  endtask

  // loads to r20..r23, alu results to r24..r27, sources from r0..r15
  task automatic test_dual_pairs();
    for (int i = 0; i < 4; i++) begin
      if (i % 2 == 0) prog_q.push_back(mk_load(pick_dest(3'b101), lfsr_bits(32)));
      prog_q.push_back(mk_alu(pick_op(), pick_src(), pick_src(), pick_dest(3'b110)));
      if (i % 2 == 1) prog_q.push_back(mk_load(pick_dest(3'b101), lfsr_bits(32)));
    end
    run_prog();
    drain();
  endtask

  task automatic test_same_class();
    repeat (3) prog_q.push_back(mk_load(pick_dest(3'b101), lfsr_bits(32)));
    run_prog();
    repeat (3) prog_q.push_back(mk_alu(pick_op(), pick_src(), pick_src(), pick_dest(3'b110)));
    run_prog();
    drain();
  endtask

  task automatic test_dependent_pairs();
    reg_addr_t r;
    reg_addr_t t;
    r = pick_dest(3'b111);
    t = pick_dest(3'b101);
    prog_q.push_back(mk_load(r, lfsr_bits(32)));
    prog_q.push_back(mk_alu(pick_op(), pick_src(), pick_src(), r));  // same rt
    run_prog();
    prog_q.push_back(mk_load(t, lfsr_bits(32)));
    prog_q.push_back(mk_alu(pick_op(), t, pick_src(), pick_dest(3'b110)));  // reads slot0 rt
    run_prog();
    prog_q.push_back(mk_alu(pick_op(), pick_src(), pick_src(), r));
    prog_q.push_back(mk_load(r, lfsr_bits(32)));
    run_prog();
    drain();
  endtask

  task automatic check_regs();
    for (int i = 0; i < 32; i++) begin
      check_word($sformatf("regs[%0d]", i), dut.u_regs.regs[i], ref_regs[i]);
    end
  endtask

  // writeback monitor, each port against its own queue
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (load_q.size() > 0 && load_q[0].at == cyc) begin
        compare_wb("wb_load", wb_load_en, wb_load_addr, wb_load_data, load_q[0].wb);
        void'(load_q.pop_front());
      end else if (wb_load_en) begin
        other_errs++;
        $display("unexpected writeback on the load port in cycle %0d", cyc);
      end
      if (alu_q.size() > 0 && alu_q[0].at == cyc) begin
        compare_wb("wb_alu", wb_alu_en, wb_alu_addr, wb_alu_data, alu_q[0].wb);
        void'(alu_q.pop_front());
      end else if (wb_alu_en) begin
        other_errs++;
        $display("unexpected writeback on the alu port in cycle %0d", cyc);
      end
    end
  end

  initial begin
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
      last_take[i] = -100;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_idle();
    test_single_loads();
    test_dependent_alu();
    test_dual_pairs();
    test_same_class();
    test_dependent_pairs();
    check_regs();
    finish_run();
  end

endmodule

// File: src/alu_lane.sv
`timescale 1ns/1ns

module alu_lane (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 take0,
  input  logic                 take1,
  input  issue_pkg::instr_t    load_instr,
  input  issue_pkg::instr_t    alu_instr,
  input  logic                 load_from_slot1,
  input  logic                 alu_used,
  input  issue_pkg::word_t     a_data,
  input  issue_pkg::word_t     b_data,
  output issue_pkg::wb_t       load_res,
  output issue_pkg::wb_t       alu_res,
  output issue_pkg::tag_pair_t new_tags
);

  import issue_pkg::*;

  logic load_v;
  logic alu_v;
  logic alu_from_slot1;
  logic ld_v_q;
  logic alu_v_q;
  reg_addr_t ld_rt_q;
  reg_addr_t alu_rt_q;
  word_t ld_imm_q;
  word_t a_q;
  word_t b_q;
  alu_op_e op_q;
  word_t alu_val;

  // slot0 is a load and the alu lane is busy, so the alu op came from slot1
  assign alu_from_slot1 = !load_from_slot1 && (load_instr.cls == CLS_LOAD);
  assign load_v = load_from_slot1 ? take1 : (take0 && load_instr.cls == CLS_LOAD);
  assign alu_v = alu_used && (alu_from_slot1 ? take1 : take0);

  assign new_tags = {{alu_v, alu_instr.rt}, {load_v, load_instr.rt}};

  always_comb begin
    case (op_q)
      OP_ADD:  alu_val = a_q + b_q;
      OP_SUB:  alu_val = a_q - b_q;
      OP_AND:  alu_val = a_q & b_q;
      OP_OR:   alu_val = a_q | b_q;
      OP_XOR:  alu_val = a_q ^ b_q;
      default: alu_val = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    // operand stage, end of T
    ld_rt_q <= load_instr.rt;
    ld_imm_q <= load_instr.imm;
    alu_rt_q <= alu_instr.rt;
    op_q <= alu_instr.op;
    a_q <= a_data;
    b_q <= b_data;
    // result stage, end of T+1
    load_res.addr <= ld_rt_q;
    load_res.data <= ld_imm_q;  // load is just the immediate
    alu_res.addr <= alu_rt_q;
    alu_res.data <= alu_val;
    if (rst) begin
      ld_v_q <= 1'b0;
      alu_v_q <= 1'b0;
      load_res.valid <= 1'b0;
      alu_res.valid <= 1'b0;
    end else begin
      ld_v_q <= load_v;
      alu_v_q <= alu_v;
      load_res.valid <= ld_v_q;
      alu_res.valid <= alu_v_q;
    end
  end

endmodule

// File: src/hold_timer.sv
`timescale 1ns/1ns

module hold_timer (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic done
);

  import issue_pkg::*;

  logic [HOLD_CNT_WIDTH-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (start) begin
      count <= HOLD_CNT_WIDTH'(EXEC_DEPTH);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // one cycle early so the FSM is back in ISSUE right as the slot clears
  assign done = (count == HOLD_CNT_WIDTH'(1));

endmodule

// File: src/issue_core.sv
`timescale 1ns/1ns

module issue_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pair_valid,
  input  issue_pkg::instr_t    slot0_instr,
  input  issue_pkg::instr_t    slot1_instr,
  output logic                 take0,
  output logic                 take1,
  output logic                 wb_load_en,
  output logic                 wb_alu_en,
  output issue_pkg::reg_addr_t wb_load_addr,
  output issue_pkg::reg_addr_t wb_alu_addr,
  output issue_pkg::word_t     wb_load_data,
  output issue_pkg::word_t     wb_alu_data
);

  import issue_pkg::*;

  logic hazard;
  logic dual;
  logic timer_start;
  logic timer_done;
  logic load_from_slot1;
  logic alu_used;
  instr_t load_instr;
  instr_t alu_instr;
  reg_addr_t rd_addr [4];
  word_t rd_data [4];
  wb_t load_res;
  wb_t alu_res;
  wb_t wb_load;
  wb_t wb_alu;
  tag_pair_t new_tags;
  tag_pair_t tags [EXEC_DEPTH];

  assign rd_addr[0] = alu_instr.ra;
  assign rd_addr[1] = alu_instr.rb;
  assign rd_addr[2] = load_instr.ra;
  assign rd_addr[3] = load_instr.rb;

  assign wb_load_en = wb_load.valid;
  assign wb_load_addr = wb_load.addr;
  assign wb_load_data = wb_load.data;
  assign wb_alu_en = wb_alu.valid;
  assign wb_alu_addr = wb_alu.addr;
  assign wb_alu_data = wb_alu.data;

  issue_ctrl u_ctrl (
    .clk(clk), .rst(rst), .pair_valid(pair_valid), .hazard(hazard), .dual(dual),
    .timer_done(timer_done), .timer_start(timer_start), .take0(take0), .take1(take1)
  );

  hold_timer u_timer (.clk(clk), .rst(rst), .start(timer_start), .done(timer_done));

  pair_steer u_steer (
    .slot0_instr(slot0_instr), .slot1_instr(slot1_instr), .tags(tags),
    .hazard(hazard), .dual(dual), .load_instr(load_instr), .alu_instr(alu_instr),
    .load_from_slot1(load_from_slot1), .alu_used(alu_used)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .rd_addr(rd_addr), .rd_data(rd_data),
    .wr_load(wb_load), .wr_alu(wb_alu)
  );

  alu_lane u_lanes (
    .clk(clk), .rst(rst), .take0(take0), .take1(take1),
    .load_instr(load_instr), .alu_instr(alu_instr),
    .load_from_slot1(load_from_slot1), .alu_used(alu_used),
    .a_data(rd_data[0]), .b_data(rd_data[1]),
    .load_res(load_res), .alu_res(alu_res), .new_tags(new_tags)
  );

  // tags live T+1..T+EXEC_DEPTH, until the register file holds the value
  stage_pipe #(.payload_t(tag_pair_t), .DEPTH(EXEC_DEPTH)) u_tag_pipe (
    .clk(clk), .rst(rst), .in_data(new_tags), .out_data(), .taps(tags)
  );

  stage_pipe #(.payload_t(wb_t), .DEPTH(EXEC_DEPTH - 2)) u_load_pipe (
    .clk(clk), .rst(rst), .in_data(load_res), .out_data(wb_load), .taps()
  );

  stage_pipe #(.payload_t(wb_t), .DEPTH(EXEC_DEPTH - 2)) u_alu_pipe (
    .clk(clk), .rst(rst), .in_data(alu_res), .out_data(wb_alu), .taps()
  );

endmodule

// File: src/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic pair_valid,
  input  logic hazard,
  input  logic dual,
  input  logic timer_done,
  output logic timer_start,
  output logic take0,
  output logic take1
);

  typedef enum logic {
    ISSUE,
    HOLD
  } state_e;

  state_e state;
  logic go;

  // the only place the issue condition is formed
  assign go = (state == ISSUE) && pair_valid && !hazard;
  assign take0 = go;
  assign take1 = go && dual;  // slot1 never goes alone
  assign timer_start = (state == ISSUE) && pair_valid && hazard;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ISSUE;
    end else begin
      case (state)
        ISSUE: begin
          if (timer_start) state <= HOLD;
        end
        HOLD: begin
          if (timer_done) state <= ISSUE;  // recheck the slots
        end
        default: state <= ISSUE;
      endcase
    end
  end

endmodule

// File: src/issue_pkg.sv
package issue_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int EXEC_DEPTH = 4;  // cycles from take to writeback
  localparam int HOLD_CNT_WIDTH = $clog2(EXEC_DEPTH + 1);

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  typedef enum logic {
    CLS_ALU,
    CLS_LOAD
  } iclass_e;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR
  } alu_op_e;

  // ra and rb only count for alu ops, imm only for loads
  typedef struct packed {
    iclass_e   cls;
    alu_op_e   op;
    reg_addr_t ra;
    reg_addr_t rb;
    reg_addr_t rt;
    word_t     imm;
  } instr_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
  } dest_tag_t;

  // [0] load lane, [1] alu lane
  typedef dest_tag_t [1:0] tag_pair_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    word_t     data;
  } wb_t;

endpackage

// File: src/pair_steer.sv
`timescale 1ns/1ns

module pair_steer (
  input  issue_pkg::instr_t    slot0_instr,
  input  issue_pkg::instr_t    slot1_instr,
  input  issue_pkg::tag_pair_t tags [issue_pkg::EXEC_DEPTH],
  output logic                 hazard,
  output logic                 dual,
  output issue_pkg::instr_t    load_instr,
  output issue_pkg::instr_t    alu_instr,
  output logic                 load_from_slot1,
  output logic                 alu_used
);

  import issue_pkg::*;

  logic slot0_load;
  logic slot1_load;
  logic slot1_dep;
  logic classes_differ;

  // true when a source of ins is still waiting on an in-flight write
  function automatic logic src_busy(input instr_t ins, input tag_pair_t tg [EXEC_DEPTH]);
    logic hit;
    hit = 1'b0;
    if (ins.cls == CLS_ALU) begin
      for (int s = 0; s < EXEC_DEPTH; s++) begin
        for (int l = 0; l < 2; l++) begin
          if (tg[s][l].valid && (tg[s][l].addr == ins.ra || tg[s][l].addr == ins.rb)) begin
            hit = 1'b1;
          end
        end
      end
    end
    return hit;
  endfunction

  assign slot0_load = (slot0_instr.cls == CLS_LOAD);
  assign slot1_load = (slot1_instr.cls == CLS_LOAD);
  assign classes_differ = (slot0_load != slot1_load);

  // RAW on slot0's result, or WAW on the same rt
  assign slot1_dep = (slot1_instr.rt == slot0_instr.rt) ||
                     (!slot1_load && (slot1_instr.ra == slot0_instr.rt ||
                                      slot1_instr.rb == slot0_instr.rt));

  always_comb begin
    hazard = src_busy(slot0_instr, tags);
    dual = classes_differ && !slot1_dep && !src_busy(slot1_instr, tags);
  end

  // lane swap, a single issue keeps slot0 in its own class lane
  assign load_from_slot1 = dual && slot1_load;
  assign alu_used = dual || !slot0_load;
  assign load_instr = load_from_slot1 ? slot1_instr : slot0_instr;
  assign alu_instr = (dual && slot0_load) ? slot1_instr : slot0_instr;

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  issue_pkg::reg_addr_t rd_addr [4],
  output issue_pkg::word_t     rd_data [4],
  input  issue_pkg::wb_t       wr_load,
  input  issue_pkg::wb_t       wr_alu
);

  import issue_pkg::*;

  word_t regs [2**REG_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_load.valid) begin
        regs[wr_load.addr] <= wr_load.data;
      end
      if (wr_alu.valid) begin
        regs[wr_alu.addr] <= wr_alu.data;  // written last, wins a clash
      end
    end
  end

  // no bypass, a write shows up the cycle after its edge
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rd_data[p] = regs[rd_addr[p]];
    end
  end

endmodule

// File: src/stage_pipe.sv
`timescale 1ns/1ns

module stage_pipe #(
  parameter type payload_t = logic,
  parameter int DEPTH = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  output payload_t out_data,
  output payload_t taps [DEPTH]
);

  payload_t stages [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;  // drops every valid bit in flight
      end
    end else begin
      stages[0] <= in_data;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign out_data = stages[DEPTH-1];
  assign taps = stages;

endmodule

// File: verilog.f
src/issue_pkg.sv
src/stage_pipe.sv
src/hold_timer.sv
src/issue_ctrl.sv
src/pair_steer.sv
src/reg_file.sv
src/alu_lane.sv
src/issue_core.sv
sim/issue_core_assert.sv
sim/issue_core_tb.sv
